// File: filelist.f
source/kernel_pkg.sv
source/reg_bus_if.sv
source/param_port_if.sv
source/axil_ctrl_slave.sv
source/kernel_ctrl_regs.sv
source/kernel_param_mem.sv
source/param_sum_action.sv
source/sda_kernel_wrapper.sv
tests/tb_clock_gen.sv
tests/tb_kernel_wrapper.sv

// File: tests/tb_kernel_wrapper.sv
// ********************
// Testbench for the kernel wrapper. Random register, parameter and sum-run
// traffic from a fixed seed, checked against a shadow model of the design.
// ********************

`timescale 1ns/1ps

module tb_kernel_wrapper import kernel_pkg::*; ();

  localparam int NUM_MEM_OPS      = 40;
  localparam int NUM_RUNS         = 12;
  localparam int RUN_TRANSACTIONS = PARAM_DEPTH + 8;
  localparam int PLANNED_RUNS     = NUM_RUNS + 2;
  localparam int PLANNED_TRANSACTIONS =
    2 + PARAM_DEPTH + 2 * NUM_MEM_OPS + PLANNED_RUNS * RUN_TRANSACTIONS + 24;
  localparam int WATCHDOG_CYCLES  = 64 * PLANNED_TRANSACTIONS + 200 * PLANNED_RUNS;

  // Done is bit1 and idle is bit2 of REG_CTRL.
  localparam reg_word_t CTRL_STATUS_MASK = 32'h0000_0006;

  logic         ap_clk;
  logic         rst_n;
  ctrl_addr_t   awaddr;
  ctrl_addr_t   araddr;
  logic         awvalid, awready, wvalid, wready;
  logic         bvalid, bready, arvalid, arready;
  logic         rvalid, rready, interrupt;
  reg_word_t    wdata;
  reg_word_t    rdata;
  reg_strb_t    wstrb;
  axi_resp_t    bresp;
  axi_resp_t    rresp;
  int           seed = 34;

  // Shadow model of the parameter memory and the register map.
  reg_word_t    shadow_mem [PARAM_DEPTH];
  logic         m_gie;
  logic         m_ier;
  logic         m_isr;
  param_count_t m_count;
  reg_word_t    m_result;

  tb_clock_gen clock_u (.ap_clk(ap_clk), .rst_n(rst_n));

  sda_kernel_wrapper DUT (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .s_axi_control_awaddr(awaddr), .s_axi_control_awvalid(awvalid),
    .s_axi_control_awready(awready), .s_axi_control_wdata(wdata),
    .s_axi_control_wstrb(wstrb), .s_axi_control_wvalid(wvalid),
    .s_axi_control_wready(wready), .s_axi_control_bresp(bresp),
    .s_axi_control_bvalid(bvalid), .s_axi_control_bready(bready),
    .s_axi_control_araddr(araddr), .s_axi_control_arvalid(arvalid),
    .s_axi_control_arready(arready), .s_axi_control_rdata(rdata),
    .s_axi_control_rresp(rresp), .s_axi_control_rvalid(rvalid),
    .s_axi_control_rready(rready), .interrupt(interrupt)
  );

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input reg_word_t got, input reg_word_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  function automatic ctrl_addr_t byte_addr(input reg_addr_t word);
    return ctrl_addr_t'(word) << 2;
  endfunction

  function automatic reg_word_t merge_bytes(input reg_word_t old_w, input reg_word_t new_w,
                                            input reg_strb_t strb);
    reg_word_t merged;
    merged = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_w[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic reg_word_t sum_words(input int n);
    reg_word_t total;
    total = '0;
    for (int i = 0; i < n; i++) begin
      total += shadow_mem[i];
    end
    return total;
  endfunction

  // One AXI-lite write; BREADY is held off for a random number of cycles.
  task automatic write_word(input reg_addr_t word, input reg_word_t data, input reg_strb_t strb);
    int        stall;
    axi_resp_t resp;
    stall = $unsigned($random(seed)) % 6;
    @(posedge ap_clk);
    awaddr  <= byte_addr(word);
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(negedge ap_clk); while (!(awready && wready));
    @(posedge ap_clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge ap_clk); while (!bvalid);
    resp = bresp;
    repeat (stall) begin
      @(negedge ap_clk);
      if (!bvalid) begin
        $display("BVALID dropped at %0t ns before the host took the response", $time);
        fail_run();
      end
      check_resp(bresp, resp, "held BRESP");
    end
    @(posedge ap_clk);
    bready <= 1'b1;
    @(posedge ap_clk);
    bready <= 1'b0;
    check_resp(resp, RESP_OKAY, "write response");
  endtask

  // One AXI-lite read; RREADY is held off for a random number of cycles.
  task automatic read_word(input reg_addr_t word, output reg_word_t data);
    int stall;
    stall = $unsigned($random(seed)) % 6;
    @(posedge ap_clk);
    araddr  <= byte_addr(word);
    arvalid <= 1'b1;
    do @(negedge ap_clk); while (!arready);
    @(posedge ap_clk);
    arvalid <= 1'b0;
    do @(negedge ap_clk); while (!rvalid);
    data = rdata;
    check_resp(rresp, RESP_OKAY, "read response");
    repeat (stall) begin
      @(negedge ap_clk);
      if (!rvalid) begin
        $display("RVALID dropped at %0t ns before the host took the data", $time);
        fail_run();
      end
      check_word(rdata, data, "held RDATA");
    end
    @(posedge ap_clk);
    rready <= 1'b1;
    @(posedge ap_clk);
    rready <= 1'b0;
  endtask

  task automatic expect_read(input reg_addr_t word, input reg_word_t exp, input string what);
    reg_word_t value;
    read_word(word, value);
    check_word(value, exp, what);
  endtask

  // Programs parameters and count, starts a run and polls until done.
  task automatic run_sum(input int count);
    int        n;
    reg_word_t value;
    n = (count > PARAM_DEPTH) ? PARAM_DEPTH : count;
    for (int i = 0; i < n; i++) begin
      shadow_mem[i] = $random(seed);
      write_word(PARAM_BASE + reg_addr_t'(i), shadow_mem[i], 4'hF);
    end
    write_word(REG_COUNT, reg_word_t'(count), 4'hF);
    m_count = param_count_t'(n);
    expect_read(REG_COUNT, reg_word_t'(m_count), "COUNT");
    write_word(REG_CTRL, 32'h1, 4'hF);
    do begin
      read_word(REG_CTRL, value);
      if (!value[1]) begin
        check_word(value & CTRL_STATUS_MASK, 32'h0, "CTRL status while running");
        if (!m_gie) begin
          @(negedge ap_clk);
          check_irq(interrupt, 1'b0, "interrupt while running");
        end
      end
    end while (!value[1]);
    check_word(value & CTRL_STATUS_MASK, 32'h6, "CTRL status at done");
    m_result = sum_words(n);
    m_isr    = 1'b1;
    @(negedge ap_clk);
    check_irq(interrupt, m_gie & m_ier & m_isr, "interrupt at done");
    read_word(REG_CTRL, value);
    check_word(value & CTRL_STATUS_MASK, 32'h4, "CTRL status after done read");
    expect_read(REG_RESULT, m_result, "RESULT");
  endtask

  task automatic check_registers();
    reg_word_t value;
    expect_read(REG_GIE, reg_word_t'(m_gie), "GIE");
    expect_read(REG_IER, reg_word_t'(m_ier), "IER");
    expect_read(REG_ISR, reg_word_t'(m_isr), "ISR");
    expect_read(REG_COUNT, reg_word_t'(m_count), "COUNT");
    expect_read(REG_RESULT, m_result, "RESULT");
    read_word(REG_CTRL, value);
    check_word(value & CTRL_STATUS_MASK, 32'h4, "CTRL status");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    fail_run();
  end

  initial begin
    int        idx;
    int        count;
    reg_word_t data;
    reg_word_t value;
    reg_strb_t strb;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    m_gie    = 1'b0;
    m_ier    = 1'b0;
    m_isr    = 1'b0;
    m_count  = '0;
    m_result = '0;
    wait (rst_n === 1'b1);

    // State right after reset.
    read_word(REG_CTRL, value);
    check_word(value & CTRL_STATUS_MASK, 32'h4, "CTRL status after reset");
    expect_read(REG_RESULT, 32'h0, "RESULT after reset");
    @(negedge ap_clk);
    check_irq(interrupt, 1'b0, "interrupt after reset");

    // Fill the whole memory, then partial-strobe updates with read-back.
    for (int i = 0; i < PARAM_DEPTH; i++) begin
      shadow_mem[i] = $random(seed);
      write_word(PARAM_BASE + reg_addr_t'(i), shadow_mem[i], 4'hF);
    end
    repeat (NUM_MEM_OPS) begin
      idx  = $unsigned($random(seed)) % PARAM_DEPTH;
      data = $random(seed);
      strb = ($random(seed) & 1) ? 4'hF : reg_strb_t'($random(seed));
      shadow_mem[idx] = merge_bytes(shadow_mem[idx], data, strb);
      write_word(PARAM_BASE + reg_addr_t'(idx), data, strb);
      expect_read(PARAM_BASE + reg_addr_t'(idx), shadow_mem[idx], "parameter word");
    end

    // Sum runs; the first two cover an empty run and a saturated count.
    for (int r = 0; r < NUM_RUNS; r++) begin
      if (r == 0) count = 0;
      else if (r == 1) count = 70;
      else count = $unsigned($random(seed)) % 71;
      run_sum(count);
    end

    // Interrupt enabled.
    write_word(REG_ISR, 32'h1, 4'hF);
    m_isr = 1'b0;
    write_word(REG_GIE, 32'h1, 4'hF);
    m_gie = 1'b1;
    write_word(REG_IER, 32'h1, 4'hF);
    m_ier = 1'b1;
    @(negedge ap_clk);
    check_irq(interrupt, 1'b0, "interrupt before run");
    run_sum($unsigned($random(seed)) % 65);
    repeat (10) @(negedge ap_clk);
    check_irq(interrupt, 1'b1, "interrupt held after done");
    write_word(REG_ISR, 32'h1, 4'hF);
    m_isr = 1'b0;
    @(negedge ap_clk);
    check_irq(interrupt, 1'b0, "interrupt after ISR clear");

    // With the global enable off the status bit still sets and the line stays low.
    write_word(REG_GIE, 32'h0, 4'hF);
    m_gie = 1'b0;
    run_sum($unsigned($random(seed)) % 65);
    check_registers();

    // Unmapped words read as zero and writes there change nothing.
    write_word(12'h010, 32'hFFFF_FFFF, 4'hF);
    write_word(12'h300, 32'hFFFF_FFFF, 4'hF);
    expect_read(12'h010, 32'h0, "unmapped word 0x010");
    expect_read(12'h300, 32'h0, "unmapped word 0x300");
    check_registers();
    expect_read(PARAM_BASE, shadow_mem[0], "parameter word 0 after unmapped writes");
    @(negedge ap_clk);
    check_irq(interrupt, 1'b0, "interrupt after unmapped writes");

    $display("TEST OK");
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
// ********************
// Testbench clock and reset source.
// Free-running clock, reset held low for a few cycles.
// ********************

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic ap_clk,
  output logic rst_n
);

  initial begin
    ap_clk = 1'b0;
    forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
  end

  // Released on a rising edge, like any other synchronous input.
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    rst_n <= 1'b1;
  end

endmodule

// File: source/sda_kernel_wrapper.sv
// ********************
// Kernel wrapper top level. Connects the AXI-lite control port to the
// control registers, the parameter memory and the sum action.
// ********************

`timescale 1ns/1ps

module sda_kernel_wrapper import kernel_pkg::*; #(
  parameter int PARAM_DEPTH_P = PARAM_DEPTH
) (
  input  logic       ap_clk,
  input  logic       rst_n,
  input  ctrl_addr_t s_axi_control_awaddr,
  input  logic       s_axi_control_awvalid,
  output logic       s_axi_control_awready,
  input  reg_word_t  s_axi_control_wdata,
  input  reg_strb_t  s_axi_control_wstrb,
  input  logic       s_axi_control_wvalid,
  output logic       s_axi_control_wready,
  output axi_resp_t  s_axi_control_bresp,
  output logic       s_axi_control_bvalid,
  input  logic       s_axi_control_bready,
  input  ctrl_addr_t s_axi_control_araddr,
  input  logic       s_axi_control_arvalid,
  output logic       s_axi_control_arready,
  output reg_word_t  s_axi_control_rdata,
  output axi_resp_t  s_axi_control_rresp,
  output logic       s_axi_control_rvalid,
  input  logic       s_axi_control_rready,
  output logic       interrupt
);

  logic         ctrl_ack;
  logic         mem_ack;
  reg_word_t    ctrl_rdata;
  reg_word_t    mem_rdata;
  logic         go_valid;
  logic         go_ready;
  param_count_t go_count;
  logic         done_valid;
  logic         done_ready;
  reg_word_t    done_result;

  reg_bus_if    reg_bus ();
  param_port_if param_port ();

  // Idle targets hold ack and rdata at zero, so OR merges them.
  assign reg_bus.ack   = ctrl_ack | mem_ack;
  assign reg_bus.rdata = ctrl_rdata | mem_rdata;

  axil_ctrl_slave ctrl_slave_u (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .awaddr(s_axi_control_awaddr), .awvalid(s_axi_control_awvalid),
    .awready(s_axi_control_awready), .wdata(s_axi_control_wdata),
    .wstrb(s_axi_control_wstrb), .wvalid(s_axi_control_wvalid),
    .wready(s_axi_control_wready), .bresp(s_axi_control_bresp),
    .bvalid(s_axi_control_bvalid), .bready(s_axi_control_bready),
    .araddr(s_axi_control_araddr), .arvalid(s_axi_control_arvalid),
    .arready(s_axi_control_arready), .rdata(s_axi_control_rdata),
    .rresp(s_axi_control_rresp), .rvalid(s_axi_control_rvalid),
    .rready(s_axi_control_rready), .bus(reg_bus.master)
  );

  kernel_ctrl_regs #(.PARAM_DEPTH_P(PARAM_DEPTH_P)) ctrl_regs_u (
    .ap_clk(ap_clk), .rst_n(rst_n), .bus(reg_bus.target),
    .bus_ack(ctrl_ack), .bus_rdata(ctrl_rdata),
    .go_valid(go_valid), .go_ready(go_ready), .go_count(go_count),
    .done_valid(done_valid), .done_ready(done_ready), .done_result(done_result),
    .interrupt(interrupt)
  );

  kernel_param_mem #(.PARAM_DEPTH_P(PARAM_DEPTH_P)) param_mem_u (
    .ap_clk(ap_clk), .rst_n(rst_n), .bus(reg_bus.target),
    .bus_ack(mem_ack), .bus_rdata(mem_rdata), .port(param_port.server)
  );

  param_sum_action action_u (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .go_valid(go_valid), .go_ready(go_ready), .go_count(go_count),
    .done_valid(done_valid), .done_ready(done_ready), .done_result(done_result),
    .port(param_port.requester)
  );

endmodule

// File: source/param_sum_action.sv
// ********************
// Action engine. On each go token it streams count parameter words and
// returns their 32-bit wrapping sum on the done token.
// ********************

`timescale 1ns/1ps

module param_sum_action import kernel_pkg::*; (
  input  logic            ap_clk,
  input  logic            rst_n,
  input  logic            go_valid,
  output logic            go_ready,
  input  param_count_t    go_count,
  output logic            done_valid,
  input  logic            done_ready,
  output reg_word_t       done_result,
  param_port_if.requester port
);

  action_state_t state;
  param_count_t  count_q;
  param_count_t  issued;
  param_count_t  received;
  reg_word_t     sum_q;
  logic          addr_fire;
  logic          data_fire;

  assign go_ready = (state == IDLE);

  assign port.addr_valid = (state == ISSUE);
  assign port.addr       = param_idx_t'(issued);
  assign port.data_ready = (state == ISSUE) || (state == DRAIN);

  assign addr_fire = port.addr_valid && port.addr_ready;
  assign data_fire = port.data_valid && port.data_ready;

  assign done_valid  = (state == REPORT);
  assign done_result = sum_q;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (go_valid) begin
            count_q  <= go_count;
            issued   <= '0;
            received <= '0;
            sum_q    <= '0;
            // Zero words goes straight to the report.
            state    <= (go_count == '0) ? REPORT : ISSUE;
          end
        end
        ISSUE: begin
          if (addr_fire) begin
            issued <= issued + 1'b1;
            if (param_count_t'(issued + 1'b1) == count_q) state <= DRAIN;
          end
        end
        DRAIN:   if (received == count_q) state <= REPORT;
        REPORT:  if (done_ready) state <= IDLE;
        default: state <= IDLE;
      endcase

      // Returned words accumulate while addresses are still going out.
      if (data_fire) begin
        sum_q    <= sum_q + port.data;
        received <= received + 1'b1;
      end
    end
  end

endmodule

// File: source/kernel_param_mem.sv
// ********************
// Parameter memory. Written and read over the register bus inside its
// window, and streamed to the action through a two-entry read queue.
// ********************

`timescale 1ns/1ps

module kernel_param_mem import kernel_pkg::*; #(
  parameter int PARAM_DEPTH_P = PARAM_DEPTH
) (
  input  logic        ap_clk,
  input  logic        rst_n,
  reg_bus_if.target   bus,
  output logic        bus_ack,
  output reg_word_t   bus_rdata,
  param_port_if.server port
);

  reg_word_t  mem [PARAM_DEPTH_P];
  reg_word_t  q_data [2];
  logic [1:0] q_count;
  logic       q_wr_ptr;
  logic       q_rd_ptr;
  logic       hit;
  param_idx_t bus_idx;
  logic       push;
  logic       pop;

  assign hit     = bus.req && in_param_window(bus.addr, PARAM_DEPTH_P);
  assign bus_idx = param_idx_t'(bus.addr - PARAM_BASE);

  // An accepted address is read straight into the queue, so occupancy
  // already counts the word on its way.
  assign push = port.addr_valid && port.addr_ready;
  assign pop  = port.data_valid && port.data_ready;

  assign port.addr_ready = (q_count != 2'd2);
  assign port.data_valid = (q_count != 2'd0);
  assign port.data       = q_data[q_rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (hit && bus.write_en) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.wstrb[b]) begin
          mem[bus_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (push) begin
      q_data[q_wr_ptr] <= mem[port.addr];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      bus_ack   <= 1'b0;
      bus_rdata <= '0;
      q_count   <= 2'd0;
      q_wr_ptr  <= 1'b0;
      q_rd_ptr  <= 1'b0;
    end else begin
      bus_ack   <= hit;
      bus_rdata <= (hit && !bus.write_en) ? mem[bus_idx] : '0;
      case ({push, pop})
        2'b10:   q_count <= q_count + 2'd1;
        2'b01:   q_count <= q_count - 2'd1;
        default: ;
      endcase
      if (push) q_wr_ptr <= !q_wr_ptr;
      if (pop) q_rd_ptr <= !q_rd_ptr;
    end
  end

endmodule

// File: source/kernel_ctrl_regs.sv
// ********************
// Kernel control registers: start/done/idle, interrupt enables and status,
// word count and result. Runs the go/done handshake with the action.
// ********************

`timescale 1ns/1ps

module kernel_ctrl_regs import kernel_pkg::*; #(
  parameter int PARAM_DEPTH_P = PARAM_DEPTH
) (
  input  logic         ap_clk,
  input  logic         rst_n,
  reg_bus_if.target    bus,
  output logic         bus_ack,
  output reg_word_t    bus_rdata,
  output logic         go_valid,
  input  logic         go_ready,
  output param_count_t go_count,
  input  logic         done_valid,
  output logic         done_ready,
  input  reg_word_t    done_result,
  output logic         interrupt
);

  logic         sel;
  logic         wr_sel;
  logic         rd_sel;
  logic         gie;
  logic         ier;
  logic         isr;
  logic         busy;
  logic         done_flag;
  logic         launch;
  param_count_t count_q;
  param_count_t count_wr;
  reg_word_t    result_q;
  reg_word_t    read_value;

  // Everything outside the parameter window is answered here.
  assign sel    = bus.req && !in_param_window(bus.addr, PARAM_DEPTH_P);
  assign wr_sel = sel && bus.write_en;
  assign rd_sel = sel && !bus.write_en;

  // Counts above the memory depth saturate.
  assign count_wr = (bus.wdata > reg_word_t'(PARAM_DEPTH_P)) ?
                    param_count_t'(PARAM_DEPTH_P) : param_count_t'(bus.wdata);

  assign go_count   = count_q;
  assign done_ready = 1'b1;

  always_comb begin
    read_value = '0;
    case (bus.addr)
      REG_CTRL:   read_value = {29'd0, !busy, done_flag, busy};
      REG_GIE:    read_value[0] = gie;
      REG_IER:    read_value[0] = ier;
      REG_ISR:    read_value[0] = isr;
      REG_COUNT:  read_value = reg_word_t'(count_q);
      REG_RESULT: read_value = result_q;
      default:    read_value = '0;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      bus_ack   <= 1'b0;
      bus_rdata <= '0;
      gie       <= 1'b0;
      ier       <= 1'b0;
      isr       <= 1'b0;
      busy      <= 1'b0;
      done_flag <= 1'b0;
      launch    <= 1'b0;
      go_valid  <= 1'b0;
      count_q   <= '0;
      result_q  <= '0;
      interrupt <= 1'b0;
    end else begin
      bus_ack   <= sel;
      bus_rdata <= rd_sel ? read_value : '0;
      launch    <= 1'b0;

      // Go rises the cycle after the start write is acknowledged.
      if (go_valid && go_ready) begin
        go_valid <= 1'b0;
      end
      if (launch) begin
        go_valid <= 1'b1;
      end

      if (wr_sel && bus.wstrb[0]) begin
        case (bus.addr)
          REG_CTRL: begin
            if (bus.wdata[0] && !busy) begin
              busy   <= 1'b1;
              launch <= 1'b1;
            end
          end
          REG_GIE:   gie <= bus.wdata[0];
          REG_IER:   ier <= bus.wdata[0];
          REG_ISR:   if (bus.wdata[0]) isr <= 1'b0;
          REG_COUNT: count_q <= count_wr;
          default:   ;
        endcase
      end

      // Done clears on read; a done token in the same cycle wins.
      if (rd_sel && (bus.addr == REG_CTRL)) begin
        done_flag <= 1'b0;
      end
      if (done_valid) begin
        result_q  <= done_result;
        busy      <= 1'b0;
        done_flag <= 1'b1;
        isr       <= 1'b1;
      end

      interrupt <= gie & ier & isr;
    end
  end

endmodule

// File: source/axil_ctrl_slave.sv
// ********************
// AXI-lite control slave. Each accepted read or write becomes one
// register bus access; the response is held until the host takes it.
// ********************

`timescale 1ns/1ps

module axil_ctrl_slave import kernel_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst_n,
  input  ctrl_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  reg_word_t  wdata,
  input  reg_strb_t  wstrb,
  input  logic       wvalid,
  output logic       wready,
  output axi_resp_t  bresp,
  output logic       bvalid,
  input  logic       bready,
  input  ctrl_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output reg_word_t  rdata,
  output axi_resp_t  rresp,
  output logic       rvalid,
  input  logic       rready,
  reg_bus_if.master  bus
);

  typedef enum logic [2:0] {S_IDLE, S_REQ, S_WAIT, S_BRESP, S_RRESP} slave_state_t;

  slave_state_t state;
  logic         write_q;
  reg_addr_t    addr_q;
  reg_word_t    wdata_q;
  reg_strb_t    wstrb_q;
  reg_word_t    rdata_q;
  logic         rd_accept;
  logic         wr_accept;

  // Byte address to register word address.
  function automatic reg_addr_t word_addr(ctrl_addr_t byte_addr);
    return reg_addr_t'(byte_addr >> 2);
  endfunction

  // Reads win when both are offered; nothing is taken while a response is pending.
  assign rd_accept = (state == S_IDLE) && arvalid;
  assign wr_accept = (state == S_IDLE) && !arvalid && awvalid && wvalid;

  assign arready = rd_accept;
  assign awready = wr_accept;
  assign wready  = wr_accept;

  assign bvalid = (state == S_BRESP);
  assign bresp  = RESP_OKAY;
  assign rvalid = (state == S_RRESP);
  assign rresp  = RESP_OKAY;
  assign rdata  = rdata_q;

  assign bus.req      = (state == S_REQ);
  assign bus.write_en = write_q;
  assign bus.addr     = addr_q;
  assign bus.wdata    = wdata_q;
  assign bus.wstrb    = wstrb_q;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      write_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (rd_accept) begin
            write_q <= 1'b0;
            state   <= S_REQ;
          end else if (wr_accept) begin
            write_q <= 1'b1;
            state   <= S_REQ;
          end
        end
        S_REQ:   state <= S_WAIT;
        S_WAIT:  if (bus.ack) state <= write_q ? S_BRESP : S_RRESP;
        S_BRESP: if (bready) state <= S_IDLE;
        S_RRESP: if (rready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Captured address, data and read result.
  always_ff @(posedge ap_clk) begin
    if (rd_accept) begin
      addr_q <= word_addr(araddr);
    end else if (wr_accept) begin
      addr_q  <= word_addr(awaddr);
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if ((state == S_WAIT) && bus.ack && !write_q) begin
      rdata_q <= bus.rdata;
    end
  end

endmodule

// File: source/param_port_if.sv
// ********************
// Parameter read stream between the parameter memory and the action engine.
// Address and data halves are each valid/ready.
// ********************

`timescale 1ns/1ps

interface param_port_if import kernel_pkg::*; ();

  logic       addr_valid;
  logic       addr_ready;
  param_idx_t addr;
  logic       data_valid;
  logic       data_ready;
  reg_word_t  data;

  modport requester (output addr_valid, addr, data_ready, input addr_ready, data_valid, data);
  modport server (input addr_valid, addr, data_ready, output addr_ready, data_valid, data);

endinterface

// File: source/reg_bus_if.sv
// ********************
// Internal register bus between the AXI-lite slave and the register targets.
// One-cycle req, ack one cycle later with rdata.
// ********************

`timescale 1ns/1ps

interface reg_bus_if import kernel_pkg::*; ();

  logic      req;
  logic      write_en;
  reg_addr_t addr;
  reg_word_t wdata;
  reg_strb_t wstrb;
  logic      ack;
  reg_word_t rdata;

  modport master (output req, write_en, addr, wdata, wstrb, input ack, rdata);

  // Targets return ack and rdata on their own ports, merged by the top level.
  modport target (input req, write_en, addr, wdata, wstrb);

endinterface

// File: source/kernel_pkg.sv
// ********************
// Widths, register map and shared types for the kernel control wrapper.
// Imported by the interfaces and every RTL module.
// ********************

package kernel_pkg;

  localparam int CTRL_ADDR_WIDTH = 16;
  localparam int REG_ADDR_WIDTH  = 12;
  localparam int PARAM_IDX_WIDTH = 6;
  localparam int PARAM_DEPTH     = 64;

  typedef logic [CTRL_ADDR_WIDTH-1:0] ctrl_addr_t;
  typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
  typedef logic [31:0]                reg_word_t;
  typedef logic [3:0]                 reg_strb_t;
  typedef logic [1:0]                 axi_resp_t;
  typedef logic [PARAM_IDX_WIDTH-1:0] param_idx_t;
  typedef logic [PARAM_IDX_WIDTH:0]   param_count_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Control register word offsets.
  localparam reg_addr_t REG_CTRL   = 12'h000;
  localparam reg_addr_t REG_GIE    = 12'h001;
  localparam reg_addr_t REG_IER    = 12'h002;
  localparam reg_addr_t REG_ISR    = 12'h003;
  localparam reg_addr_t REG_COUNT  = 12'h004;
  localparam reg_addr_t REG_RESULT = 12'h005;

  // Parameter memory window starts at byte 0x800.
  localparam reg_addr_t PARAM_BASE = 12'h200;

  typedef enum logic [1:0] {IDLE, ISSUE, DRAIN, REPORT} action_state_t;

  // True when a word address falls inside a parameter window of the given depth.
  function automatic logic in_param_window(reg_addr_t addr, int unsigned depth);
    return (addr >= PARAM_BASE) && ((addr - PARAM_BASE) < depth);
  endfunction

endpackage
